//--- include/exp_table.svh
// Case items of the exponential gain table, included inside a case on a 5-bit index
// Entry i holds round(4095 * 2^(-i/32)), the gain for one 1/32 octave step
// The enclosing block must declare exp_mant as a 12-bit variable
`ifndef EXP_TABLE_SVH
`define EXP_TABLE_SVH

5'd0:  exp_mant = 12'd4095;  // Unity gain at zero attenuation
5'd1:  exp_mant = 12'd4007;
5'd2:  exp_mant = 12'd3921;
5'd3:  exp_mant = 12'd3837;
5'd4:  exp_mant = 12'd3755;
5'd5:  exp_mant = 12'd3675;
5'd6:  exp_mant = 12'd3596;
5'd7:  exp_mant = 12'd3519;
5'd8:  exp_mant = 12'd3443;  // Quarter octave down
5'd9:  exp_mant = 12'd3370;
5'd10: exp_mant = 12'd3297;
5'd11: exp_mant = 12'd3227;
5'd12: exp_mant = 12'd3158;
5'd13: exp_mant = 12'd3090;
5'd14: exp_mant = 12'd3024;
5'd15: exp_mant = 12'd2959;
5'd16: exp_mant = 12'd2896;  // Half octave, 4095 / sqrt(2)
5'd17: exp_mant = 12'd2834;
5'd18: exp_mant = 12'd2773;
5'd19: exp_mant = 12'd2713;
5'd20: exp_mant = 12'd2655;
5'd21: exp_mant = 12'd2598;
5'd22: exp_mant = 12'd2543;
5'd23: exp_mant = 12'd2488;
5'd24: exp_mant = 12'd2435;  // Three quarters of an octave down
5'd25: exp_mant = 12'd2383;
5'd26: exp_mant = 12'd2332;
5'd27: exp_mant = 12'd2282;
5'd28: exp_mant = 12'd2233;
5'd29: exp_mant = 12'd2185;
5'd30: exp_mant = 12'd2138;
5'd31: exp_mant = 12'd2092;  // Next entry would be the halved gain of the next shift

`endif

//--- source/opl3_pkg.sv
// Shared widths and types for the operator attenuation-to-gain pipeline
// One attenuation unit is 0.1875 dB and the attenuation saturates at 511
// The operator index width is derived from the operator count of one frame
package opl3_pkg;

    localparam int REG_FNUM_WIDTH  = 10;  // F-number register field
    localparam int REG_BLOCK_WIDTH = 3;   // Octave block register field
    localparam int REG_KSL_WIDTH   = 2;   // Key scale level setting
    localparam int REG_TL_WIDTH    = 6;   // Total level, 0.75 dB per step

    localparam int ATTEN_WIDTH     = 9;   // Attenuation in 0.1875 dB units
    localparam int KSL_ADD_WIDTH   = 8;   // Largest key-scale addition is 224
    localparam int GAIN_WIDTH      = 12;  // Unsigned linear gain

    localparam int NUM_OPERATORS   = 36;  // Two banks of 18 operator slots
    localparam int OP_IDX_WIDTH    = $clog2(NUM_OPERATORS);

    typedef logic [OP_IDX_WIDTH-1:0] op_idx_t;
    typedef logic [ATTEN_WIDTH-1:0]  atten_t;
    typedef logic [GAIN_WIDTH-1:0]   gain_t;

    // Register settings of one operator as they arrive with the sample
    typedef struct packed {
        logic [REG_FNUM_WIDTH-1:0]  fnum;   // Top four bits select the KSL ROM row
        logic [REG_BLOCK_WIDTH-1:0] block;
        logic [REG_KSL_WIDTH-1:0]   ksl;
        logic [REG_TL_WIDTH-1:0]    tl;
    } op_regs_t;

    // Side data that waits while the key-scale ROM works
    typedef struct packed {
        op_idx_t op_idx;
        atten_t  env;                       // Envelope level from the EG, not computed here
    } level_side_t;

    // Side data that follows the sum and gain stages
    typedef struct packed {
        op_idx_t op_idx;
    } gain_side_t;

endpackage

//--- source/ksl_add_rom.sv
// Key-scale-level addition with two cycles of latency and no valid of its own
// ROM values come from the real chip; only the top four F-number bits are used
// Output is in 0.1875 dB units and is zero for KSL 0 or low notes
`timescale 1ns/1ps

module ksl_add_rom
    import opl3_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [REG_FNUM_WIDTH-1:0]  fnum,
    input  logic [REG_BLOCK_WIDTH-1:0] block,
    input  logic [REG_KSL_WIDTH-1:0]   ksl,
    output logic [KSL_ADD_WIDTH-1:0]   ksl_add
);
    localparam logic signed [KSL_ADD_WIDTH-1:0] BLOCK_BIAS = 8;  // Block 8 would be the top octave

    logic [3:0]                      fnum_hi;
    logic [6:0]                      rom_q;       // ROM row, cycle 1
    logic signed [KSL_ADD_WIDTH-1:0] blk_ofs_q;   // Block minus 8, cycle 1
    logic [REG_KSL_WIDTH-1:0]        ksl_q;       // KSL setting aligned with cycle 1
    logic signed [KSL_ADD_WIDTH-1:0] level_t;     // T = R + 8 * (block - 8), range -64 to 56
    logic [KSL_ADD_WIDTH-1:0]        level_pos;   // T as unsigned once known positive

    assign fnum_hi = fnum[REG_FNUM_WIDTH-1 -: 4];  // Row select

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rom_q     <= '0;
            blk_ofs_q <= '0;
            ksl_q     <= '0;
        end else begin
            case (fnum_hi)
                4'd0:  rom_q <= 7'd0;
                4'd1:  rom_q <= 7'd32;
                4'd2:  rom_q <= 7'd40;
                4'd3:  rom_q <= 7'd45;
                4'd4:  rom_q <= 7'd48;
                4'd5:  rom_q <= 7'd51;
                4'd6:  rom_q <= 7'd53;
                4'd7:  rom_q <= 7'd55;
                4'd8:  rom_q <= 7'd56;
                4'd9:  rom_q <= 7'd58;
                4'd10: rom_q <= 7'd59;
                4'd11: rom_q <= 7'd60;
                4'd12: rom_q <= 7'd61;
                4'd13: rom_q <= 7'd62;
                4'd14: rom_q <= 7'd63;
                4'd15: rom_q <= 7'd64;
            endcase
            blk_ofs_q <= $signed(KSL_ADD_WIDTH'(block)) - BLOCK_BIAS;  // Always negative
            ksl_q     <= ksl;
        end
    end

    assign level_t   = $signed(KSL_ADD_WIDTH'(rom_q)) + (blk_ofs_q <<< 3);
    assign level_pos = $unsigned(level_t);

    // The scale factors follow the chip: KSL 1 doubles, KSL 3 quadruples
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ksl_add <= '0;
        end else if (ksl_q == '0 || level_t <= 0) begin
            ksl_add <= '0;                  // No scaling, or clamped at low notes
        end else begin
            case (ksl_q)
                2'd1:    ksl_add <= level_pos << 1;
                2'd2:    ksl_add <= level_pos;
                default: ksl_add <= level_pos << 2;  // KSL 3, max 224 fits the width
            endcase
        end
    end

endmodule

//--- source/stage_delay.sv
// Fixed-depth delay line for a valid strobe and a payload of any packed type
// There is no stall; every entry moves on each clock
// DEPTH must be at least 1
`timescale 1ns/1ps

module stage_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);
    logic [DEPTH-1:0] valid_q;              // Index 0 is the newest entry
    payload_t         data_q [DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                data_q[i] <= '0;
            end
        end else begin
            valid_q[0] <= in_valid;
            data_q[0]  <= in_data;          // Moves even when invalid, downstream ignores it
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
                data_q[i]  <= data_q[i-1];
            end
        end
    end

    assign out_valid = valid_q[DEPTH-1];
    assign out_data  = data_q[DEPTH-1];

endmodule

//--- source/atten_sum.sv
// Total attenuation of one operator, registered one cycle after its strobe
// Sum is envelope + 4 * total level + key-scale addition
// Anything above 511 is clamped to 511, which is the silent end of the scale
`timescale 1ns/1ps

module atten_sum
    import opl3_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  logic [KSL_ADD_WIDTH-1:0] ksl_add,
    input  logic [REG_TL_WIDTH-1:0]  tl,
    input  atten_t                   env,
    output logic                     atten_valid,
    output atten_t                   atten
);
    // Worst case is 511 + 252 + 224 = 987, so two extra bits cover it
    localparam int     SUM_WIDTH = ATTEN_WIDTH + 2;
    localparam atten_t ATTEN_MAX = '1;

    logic [SUM_WIDTH-1:0] env_ext;
    logic [SUM_WIDTH-1:0] tl_ext;          // Total level in attenuation units
    logic [SUM_WIDTH-1:0] ksl_ext;
    logic [SUM_WIDTH-1:0] sum_wide;
    atten_t               sum_sat;

    assign env_ext = SUM_WIDTH'(env);
    assign tl_ext  = SUM_WIDTH'(tl) << 2;  // One TL step is 0.75 dB, four units
    assign ksl_ext = SUM_WIDTH'(ksl_add);

    assign sum_wide = env_ext + tl_ext + ksl_ext;

    always_comb begin
        if (sum_wide > SUM_WIDTH'(ATTEN_MAX)) begin
            sum_sat = ATTEN_MAX;           // Saturate rather than wrap to a loud level
        end else begin
            sum_sat = sum_wide[ATTEN_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            atten_valid <= 1'b0;
            atten       <= '0;
        end else begin
            atten_valid <= in_valid;
            atten       <= sum_sat;        // Registered every cycle, qualified by the strobe
        end
    end

endmodule

//--- source/atten_to_gain.sv
// Attenuation to linear gain through a 32-entry exponential table and a shift
// Low five bits pick the table entry, high four bits halve the gain per step
// The input attenuation is re-registered so it leaves together with its gain
`timescale 1ns/1ps

module atten_to_gain
    import opl3_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   in_valid,
    input  atten_t atten,
    output logic   gain_valid,
    output gain_t  gain,
    output atten_t atten_out
);
    logic [4:0] tab_idx;                   // Fraction of an octave in 1/32 steps
    logic [3:0] oct_shift;                 // Whole octaves, each one halves the gain
    gain_t      exp_mant;                  // Table entry for tab_idx
    gain_t      gain_next;

    assign tab_idx   = atten[4:0];
    assign oct_shift = atten[ATTEN_WIDTH-1:5];

    always_comb begin
        exp_mant = '0;
        case (tab_idx)
            `include "exp_table.svh"
        endcase
    end

    // A shift of 12 or more gives zero, so 511 ends at 2092 >> 15
    assign gain_next = exp_mant >> oct_shift;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gain_valid <= 1'b0;
            gain       <= '0;
            atten_out  <= '0;
        end else begin
            gain_valid <= in_valid;
            gain       <= gain_next;
            atten_out  <= atten;           // Keeps out_atten aligned with out_gain
        end
    end

endmodule

//--- source/operator_level.sv
// Attenuation-to-gain path of one time-multiplexed FM operator slot
// Latency is four cycles from in_valid to out_valid, one sample may enter per clock
// There is no back-pressure; the consumer must take every output
// Data on cycles without a strobe still moves through and is ignored
`timescale 1ns/1ps

module operator_level
    import opl3_pkg::*;
#(
    parameter int SIDE_DEPTH = 2           // Must equal the ksl_add_rom latency
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  op_idx_t  in_op_idx,
    input  op_regs_t in_regs,
    input  atten_t   in_env,
    output logic     out_valid,
    output op_idx_t  out_op_idx,
    output atten_t   out_atten,
    output gain_t    out_gain
);
    localparam int GAIN_DEPTH = 2;         // One cycle in atten_sum, one in atten_to_gain

    // The total level waits beside the ROM together with the index and envelope
    typedef struct packed {
        level_side_t             side;
        logic [REG_TL_WIDTH-1:0] tl;
    } front_side_t;

    front_side_t              front_in;
    front_side_t              front_out;
    logic                     front_valid;  // Strobe aligned with ksl_add
    logic [KSL_ADD_WIDTH-1:0] ksl_add;
    logic                     atten_valid;
    atten_t                   atten;
    logic                     gain_valid;
    gain_side_t               back_in;
    gain_side_t               back_out;
    logic                     back_valid;

    assign front_in.side.op_idx = in_op_idx;
    assign front_in.side.env    = in_env;
    assign front_in.tl          = in_regs.tl;

    ksl_add_rom ksl_add_rom_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .fnum    (in_regs.fnum),
        .block   (in_regs.block),
        .ksl     (in_regs.ksl),
        .ksl_add (ksl_add)
    );

    stage_delay #(
        .payload_t (front_side_t),
        .DEPTH     (SIDE_DEPTH)
    ) front_delay_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (front_in),
        .out_valid (front_valid),
        .out_data  (front_out)
    );

    atten_sum atten_sum_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (front_valid),
        .ksl_add     (ksl_add),
        .tl          (front_out.tl),
        .env         (front_out.side.env),
        .atten_valid (atten_valid),
        .atten       (atten)
    );

    atten_to_gain atten_to_gain_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (atten_valid),
        .atten      (atten),
        .gain_valid (gain_valid),
        .gain       (out_gain),
        .atten_out  (out_atten)
    );

    assign back_in.op_idx = front_out.side.op_idx;

    stage_delay #(
        .payload_t (gain_side_t),
        .DEPTH     (GAIN_DEPTH)
    ) back_delay_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (front_valid),
        .in_data   (back_in),
        .out_valid (back_valid),
        .out_data  (back_out)
    );

    assign out_valid  = gain_valid & back_valid;  // Both strobes coincide, the AND keeps them tied
    assign out_op_idx = back_out.op_idx;

endmodule

//--- tests/operator_level_assertions.sv
// Concurrent checks bound into operator_level on strobe timing, reset and saturation
// Timing checks are disabled while arst_n is low
// The reset check looks one cycle after each reset cycle, once the flops have settled
`timescale 1ns/1ps

module operator_level_assertions
    import opl3_pkg::*;
(
    input logic                     clk,
    input logic                     arst_n,
    input logic                     in_valid,
    input logic                     front_valid,
    input logic                     atten_valid,
    input logic                     gain_valid,
    input logic                     out_valid,
    input logic [KSL_ADD_WIDTH-1:0] ksl_add,
    input logic [REG_TL_WIDTH-1:0]  tl,
    input atten_t                   env,
    input atten_t                   atten,
    input atten_t                   out_atten
);
    localparam int     LATENCY   = 4;       // Two ROM cycles, one sum cycle, one gain cycle
    localparam atten_t ATTEN_MAX = '1;      // 511, the silent end of the scale

    int     sum_in;                         // Unclamped sum at the atten_sum inputs
    atten_t sum_sat;                        // Same sum clamped at the silent end

    assign sum_in  = int'(env) + 4 * int'(tl) + int'(ksl_add);
    assign sum_sat = (sum_in > int'(ATTEN_MAX)) ? ATTEN_MAX : atten_t'(sum_in);

    latency_check: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, LATENCY))
        else $error("out_valid is not in_valid delayed by %0d cycles", LATENCY);

    reset_check: assert property (@(posedge clk)
        !arst_n |=> (!front_valid && !atten_valid && !gain_valid && !out_valid))
        else $error("A valid strobe is high while reset is held");

    // Sums above 511 must clamp to 511 instead of wrapping to a loud level
    saturation_check: assert property (@(posedge clk) disable iff (!arst_n)
        atten_valid |-> (!$isunknown(atten) && atten == $past(sum_sat)))
        else $error("Attenuation is unknown or not the input sum clamped at 511");

    // The gain stage only re-registers the sum, so the output must match it
    alignment_check: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> out_atten == $past(atten))
        else $error("out_atten does not match the sum of the previous cycle");

endmodule

bind operator_level operator_level_assertions operator_level_assertions_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .front_valid (front_valid),
    .atten_valid (atten_valid),
    .gain_valid  (gain_valid),
    .out_valid   (out_valid),
    .ksl_add     (ksl_add),
    .tl          (front_out.tl),
    .env         (front_out.side.env),
    .atten       (atten),
    .out_atten   (out_atten)
);

//--- tests/operator_level_tb.sv
// Testbench for operator_level with a reference model and an in-order scoreboard
// Inputs change 10 ns after each rising edge, outputs are compared on the falling edge
// Stops at the first mismatch; a watchdog bounds the run from the sample count
`timescale 1ns/1ps

module operator_level_tb
    import opl3_pkg::*;
();
    localparam int          CLK_PERIOD    = 100;
    localparam int          DRIVE_DELAY   = 10;
    localparam int          RESET_CYCLES  = 5;
    localparam logic [31:0] SEED          = 32'h239e;
    localparam int          SWEEP_COUNT   = 512;  // 16 ROM rows x 8 blocks x 4 KSL values
    localparam int          SAT_COUNT     = 16;
    localparam int          RAMP_COUNT    = 512;  // Every attenuation from 0 to 511
    localparam int          RANDOM_COUNT  = 400;
    localparam int          TOTAL_SAMPLES = 1 + SWEEP_COUNT + SAT_COUNT + RAMP_COUNT + RANDOM_COUNT;
    localparam int          DRAIN_CYCLES  = 20;

    typedef struct packed {
        op_idx_t op_idx;
        atten_t  atten;
        gain_t   gain;
    } expect_t;

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    op_idx_t  in_op_idx;
    op_regs_t in_regs;
    atten_t   in_env;
    logic     out_valid;
    op_idx_t  out_op_idx;
    atten_t   out_atten;
    gain_t    out_gain;

    expect_t     exp_q [$];                   // Samples in flight, oldest first
    logic [31:0] lfsr_state;
    int          sent_count;
    int          out_count;

    operator_level #(
        .SIDE_DEPTH (2)
    ) operator_level_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_op_idx  (in_op_idx),
        .in_regs    (in_regs),
        .in_env     (in_env),
        .out_valid  (out_valid),
        .out_op_idx (out_op_idx),
        .out_atten  (out_atten),
        .out_gain   (out_gain)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Fibonacci LFSR with taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);  // One step for every bit taken
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic op_regs_t random_regs();
        op_regs_t r;
        r.fnum  = REG_FNUM_WIDTH'(take_bits(REG_FNUM_WIDTH));
        r.block = REG_BLOCK_WIDTH'(take_bits(REG_BLOCK_WIDTH));
        r.ksl   = REG_KSL_WIDTH'(take_bits(REG_KSL_WIDTH));
        r.tl    = REG_TL_WIDTH'(take_bits(REG_TL_WIDTH));
        return r;
    endfunction

    // Key-scale ROM of the chip, indexed by the top four F-number bits
    function automatic int ksl_rom_row(int row);
        case (row)
            0:       return 0;
            1:       return 32;
            2:       return 40;
            3:       return 45;
            4:       return 48;
            5:       return 51;
            6:       return 53;
            7:       return 55;
            8:       return 56;
            9:       return 58;
            10:      return 59;
            11:      return 60;
            12:      return 61;
            13:      return 62;
            14:      return 63;
            default: return 64;
        endcase
    endfunction

    function automatic int exp_entry(int i);
        real r;
        r = 4095.0 * (2.0 ** (-i / 32.0));  // 1/32 octave per step
        return $rtoi(r + 0.5);
    endfunction

    function automatic expect_t ref_model(op_idx_t idx, op_regs_t regs, atten_t env);
        int      level;
        int      ksl_add;
        int      sum;
        expect_t r;
        level = ksl_rom_row(int'(regs.fnum[REG_FNUM_WIDTH-1 -: 4])) + 8 * (int'(regs.block) - 8);
        if (regs.ksl == 0 || level <= 0) ksl_add = 0;
        else if (regs.ksl == 1) ksl_add = 2 * level;
        else if (regs.ksl == 2) ksl_add = level;
        else ksl_add = 4 * level;
        sum = int'(env) + 4 * int'(regs.tl) + ksl_add;
        if (sum > 511) sum = 511;           // Saturate at the silent end
        r.op_idx = idx;
        r.atten  = atten_t'(sum);
        r.gain   = gain_t'(exp_entry(sum % 32) >> (sum / 32));
        return r;
    endfunction

    task automatic send_sample(op_idx_t idx, op_regs_t regs, atten_t env);
        in_valid  = 1'b1;
        in_op_idx = idx;
        in_regs   = regs;
        in_env    = env;
        exp_q.push_back(ref_model(idx, regs, env));
        sent_count++;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic idle_cycles(int n);
        in_valid = 1'b0;                    // Stale data stays on the bus and is ignored
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic check_op_idx(op_idx_t got, op_idx_t expv);
        if (got !== expv) begin
            $display("[FAIL] out_op_idx got 0x%0h expected 0x%0h", got, expv);
            stop_with_failure();
        end
    endtask

    task automatic check_atten(atten_t got, atten_t expv);
        if (got !== expv) begin
            $display("[FAIL] out_atten got 0x%0h expected 0x%0h", got, expv);
            stop_with_failure();
        end
    endtask

    task automatic check_gain(gain_t got, gain_t expv);
        if (got !== expv) begin
            $display("[FAIL] out_gain got 0x%0h expected 0x%0h", got, expv);
            stop_with_failure();
        end
    endtask

    // Outputs are stable mid-cycle, so the scoreboard samples on the falling edge
    always @(negedge clk) begin : compare
        expect_t expv;
        if (arst_n === 1'b1 && out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Output strobe with op_idx 0x%0h had no sample to match", out_op_idx);
                stop_with_failure();
            end else begin
                expv = exp_q.pop_front();
                check_op_idx(out_op_idx, expv.op_idx);
                check_atten(out_atten, expv.atten);
                check_gain(out_gain, expv.gain);
                out_count++;
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (TOTAL_SAMPLES * 2 + 100));
        $display("Timeout after %0d cycles with %0d samples still expected",
                 TOTAL_SAMPLES * 2 + 100, exp_q.size());
        stop_with_failure();
    end

    initial begin : stimulus
        op_regs_t regs;
        int       k;
        int       n;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_op_idx  = '0;
        in_regs    = '0;
        in_env     = '0;
        lfsr_state = SEED;
        sent_count = 0;
        out_count  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        idle_cycles(8);                     // Any strobe here has no sample and fails

        regs = random_regs();
        send_sample(op_idx_t'(0), regs, atten_t'(take_bits(ATTEN_WIDTH)));
        in_valid = 1'b0;
        k = 1;                              // Cycles since the first strobe was driven
        while (out_valid !== 1'b1 && k < 12) begin
            @(posedge clk);
            #DRIVE_DELAY;
            k++;
        end
        if (k != 4) begin
            $display("[FAIL] out_valid latency got 0x%0h expected 0x4", k);
            stop_with_failure();
        end
        idle_cycles(4);

        n = 0;
        for (int row = 0; row < 16; row++) begin
            for (int blk = 0; blk < 8; blk++) begin
                for (int ksl = 0; ksl < 4; ksl++) begin
                    regs.fnum  = REG_FNUM_WIDTH'((row << 6) | take_bits(6));  // Low bits are free
                    regs.block = REG_BLOCK_WIDTH'(blk);
                    regs.ksl   = REG_KSL_WIDTH'(ksl);
                    regs.tl    = '0;
                    send_sample(op_idx_t'(n % NUM_OPERATORS), regs, '0);
                    n++;
                end
            end
        end

        for (int i = 0; i < SAT_COUNT; i++) begin
            regs    = random_regs();
            regs.tl = REG_TL_WIDTH'(63 - take_bits(3));  // At least 224 units on its own
            send_sample(op_idx_t'(i % NUM_OPERATORS), regs, atten_t'(511 - take_bits(4)));
        end

        for (int i = 0; i < RAMP_COUNT; i++) begin
            regs     = random_regs();
            regs.ksl = '0;                  // No key scaling, so the envelope is the attenuation
            regs.tl  = '0;
            send_sample(op_idx_t'(i % NUM_OPERATORS), regs, atten_t'(i));
        end

        for (int i = 0; i < RANDOM_COUNT; i++) begin
            regs = random_regs();
            send_sample(op_idx_t'(take_bits(OP_IDX_WIDTH) % NUM_OPERATORS), regs,
                        atten_t'(take_bits(ATTEN_WIDTH)));
            if (take_bits(2) == 0) begin
                idle_cycles(take_bits(1) + 1);  // Gap of one or two cycles
            end
        end
        in_valid = 1'b0;

        k = 0;
        while (exp_q.size() != 0 && k < DRAIN_CYCLES) begin
            @(posedge clk);
            k++;
        end
        idle_cycles(8);                     // Late extra strobes would fail in compare

        if (exp_q.size() != 0 || out_count != sent_count) begin
            $display("Sent %0d samples but %0d came out", sent_count, out_count);
            stop_with_failure();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

//--- operator_level.f
+incdir+include
source/opl3_pkg.sv
source/ksl_add_rom.sv
source/stage_delay.sv
source/atten_sum.sv
source/atten_to_gain.sv
source/operator_level.sv
tests/operator_level_assertions.sv
tests/operator_level_tb.sv
